// ==== Makefile ====
# Verilator build and run for the mspe testbench

VERILATOR ?= verilator
TOP       ?= mspe_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
rtl/mspe_pkg.sv
rtl/job_decoder.sv
rtl/dram_read_arbiter.sv
rtl/lane_core.sv
rtl/packet_merger.sv
rtl/mspe.sv
sim/mspe_asserts.sv
sim/mspe_tb.sv

// ==== rtl/dram_read_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_read_arbiter (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [mspe_pkg::num_cores-1:0]     rd_req,
    input  wire  [mspe_pkg::addr_w-1:0]        rd_addr [mspe_pkg::num_cores],
    input  wire  [mspe_pkg::burst_w-1:0]       rd_count [mspe_pkg::num_cores],
    output logic [mspe_pkg::num_cores-1:0]     rd_grant,
    output logic [mspe_pkg::num_cores-1:0]     rd_data_valid,
    output logic [mspe_pkg::line_w-1:0]        rd_data,
    input  wire                                m0_waitrequest,
    input  wire  [mspe_pkg::line_w-1:0]        m0_readdata,
    input  wire                                m0_readdatavalid,
    output logic                               m0_read,
    output logic [mspe_pkg::addr_w-1:0]        m0_address,
    output logic [mspe_pkg::burst_w-1:0]       m0_burstcount
);

    logic                              burst_open; // command pending or beats still due
    logic [mspe_pkg::core_idx_w-1:0]   owner;
    logic [mspe_pkg::core_idx_w-1:0]   rr_ptr;
    logic [mspe_pkg::core_idx_w-1:0]   sel;
    logic                              sel_ok;
    logic [mspe_pkg::burst_w-1:0]      beat_cnt;

    // walk backwards so the requester nearest the pointer wins
    always_comb begin
        int idx;
        sel    = rr_ptr;
        sel_ok = 1'b0;
        for (int k = mspe_pkg::num_cores - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % mspe_pkg::num_cores;
            if (rd_req[idx]) begin
                sel    = idx[mspe_pkg::core_idx_w-1:0];
                sel_ok = 1'b1;
            end
        end
    end

    always_comb begin
        rd_grant             = '0;
        rd_data_valid        = '0;
        rd_grant[owner]      = m0_read && !m0_waitrequest;
        rd_data_valid[owner] = burst_open && m0_readdatavalid; // lines pass straight through
    end

    assign rd_data = m0_readdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            burst_open <= 1'b0;
            m0_read    <= 1'b0;
            owner      <= '0;
            rr_ptr     <= '0;
            beat_cnt   <= '0;
        end else if (!burst_open) begin
            if (sel_ok) begin
                burst_open <= 1'b1;
                m0_read    <= 1'b1;
                owner      <= sel;
                rr_ptr     <= sel + 1'b1;
            end
        end else begin
            if (m0_read && !m0_waitrequest) begin
                m0_read <= 1'b0;
            end
            if (m0_readdatavalid) begin
                if (beat_cnt + 1'b1 == m0_burstcount) begin
                    burst_open <= 1'b0; // last line of the burst is back
                    beat_cnt   <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!burst_open && sel_ok) begin
            m0_address    <= rd_addr[sel];
            m0_burstcount <= rd_count[sel];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/job_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module job_decoder (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                soft_rst,
    input  wire                                recv_fifo_valid,
    input  wire  [mspe_pkg::line_w-1:0]        recv_fifo_q,
    output logic                               recv_fifo_rdreq,
    input  wire  [mspe_pkg::num_cores-1:0]     core_busy,
    output logic [mspe_pkg::num_cores-1:0]     job_valid,
    output logic [mspe_pkg::addr_w-1:0]        job_addr,
    output mspe_pkg::lane_op_e                 job_op,
    output logic [mspe_pkg::lane_w-1:0]        job_operand,
    output logic [mspe_pkg::burst_w-1:0]       job_count
);

    logic [mspe_pkg::num_cores-1:0] idle;
    logic [mspe_pkg::num_cores-1:0] pick;

    assign idle = ~(core_busy | job_valid); // a core strobed last cycle has no busy bit yet
    assign pick = idle & (~idle + 1'b1); // lowest numbered idle core

    // a pop during reset would lose its job
    assign recv_fifo_rdreq = recv_fifo_valid && (|idle) && !(rst || soft_rst);

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            job_valid <= '0;
        end else begin
            job_valid <= recv_fifo_rdreq ? pick : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (recv_fifo_rdreq) begin
            job_addr    <= {{(mspe_pkg::addr_w - mspe_pkg::field_w){1'b0}},
                            recv_fifo_q[mspe_pkg::addr_lsb +: mspe_pkg::field_w]};
            job_op      <= mspe_pkg::lane_op_e'(recv_fifo_q[mspe_pkg::opcode_lsb +:
                                                            mspe_pkg::lane_w]);
            job_operand <= recv_fifo_q[mspe_pkg::operand_lsb +: mspe_pkg::lane_w];
            job_count   <= recv_fifo_q[mspe_pkg::count_lsb +: mspe_pkg::burst_w]; // upper bits unused
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lane_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_core (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                soft_rst,
    input  wire                                job_start,
    input  wire  [mspe_pkg::addr_w-1:0]        job_addr,
    input  wire  mspe_pkg::lane_op_e           job_op,
    input  wire  [mspe_pkg::lane_w-1:0]        job_operand,
    input  wire  [mspe_pkg::burst_w-1:0]       job_count,
    output logic                               busy,
    output logic                               rd_req,
    output logic [mspe_pkg::addr_w-1:0]        rd_addr,
    output logic [mspe_pkg::burst_w-1:0]       rd_count,
    input  wire                                rd_grant,
    input  wire                                rd_data_valid,
    input  wire  [mspe_pkg::line_w-1:0]        rd_data,
    output logic                               core_out_valid,
    output logic [mspe_pkg::line_w-1:0]        core_out_data,
    output logic                               core_out_sop,
    output logic                               core_out_eop,
    input  wire                                core_out_ready
);

    mspe_pkg::core_state_e              state;
    mspe_pkg::lane_op_e                 op;
    logic [mspe_pkg::lane_w-1:0]        operand;
    logic [mspe_pkg::line_w-1:0]        xf_next;
    logic [mspe_pkg::line_w-1:0]        xf_line;
    logic                               xf_valid;
    logic [mspe_pkg::line_w-1:0]        line_buf [mspe_pkg::max_lines];
    logic [mspe_pkg::burst_w-1:0]       rx_cnt; // lines returned from DRAM
    logic [mspe_pkg::burst_w-1:0]       wr_cnt; // lines written to the buffer
    logic [mspe_pkg::burst_w-1:0]       rd_cnt; // beats sent, also the beat number
    logic                               out_fire;

    function automatic logic [mspe_pkg::lane_w-1:0] lane_fn(
        input mspe_pkg::lane_op_e          f,
        input logic [mspe_pkg::lane_w-1:0] k,
        input logic [mspe_pkg::lane_w-1:0] x
    );
        case (f)
            mspe_pkg::op_add:  return x + k;
            mspe_pkg::op_xor:  return x ^ k;
            mspe_pkg::op_swap: return {x[7:0], x[15:8], x[23:16], x[31:24]};
            default:           return x; // pass, and any opcode we do not know
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < mspe_pkg::num_lanes; i++) begin
            xf_next[i*mspe_pkg::lane_w +: mspe_pkg::lane_w] =
                lane_fn(op, operand, rd_data[i*mspe_pkg::lane_w +: mspe_pkg::lane_w]);
        end
    end

    assign busy           = (state != mspe_pkg::core_idle);
    assign rd_req         = (state == mspe_pkg::core_request); // buffer is always empty here
    assign core_out_valid = (rd_cnt != wr_cnt);
    assign core_out_data  = line_buf[rd_cnt[mspe_pkg::buf_idx_w-1:0]];
    assign core_out_sop   = (rd_cnt == '0);
    assign core_out_eop   = (rd_cnt + 1'b1 == rd_count);
    assign out_fire       = core_out_valid && core_out_ready;

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            state    <= mspe_pkg::core_idle;
            rx_cnt   <= '0;
            wr_cnt   <= '0;
            rd_cnt   <= '0;
            xf_valid <= 1'b0;
        end else begin
            xf_valid <= rd_data_valid && (state == mspe_pkg::core_receive);
            if (xf_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (out_fire) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            case (state)
                mspe_pkg::core_idle: begin
                    if (job_start) begin
                        state <= mspe_pkg::core_request;
                    end
                end
                mspe_pkg::core_request: begin
                    if (rd_grant) begin
                        state <= mspe_pkg::core_receive;
                    end
                end
                mspe_pkg::core_receive: begin
                    if (rd_data_valid) begin
                        rx_cnt <= rx_cnt + 1'b1;
                        if (rx_cnt + 1'b1 == rd_count) begin
                            state <= mspe_pkg::core_drain;
                        end
                    end
                end
                default: begin
                    if (out_fire && core_out_eop) begin
                        state  <= mspe_pkg::core_idle; // busy drops on the next cycle
                        rx_cnt <= '0;
                        wr_cnt <= '0;
                        rd_cnt <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mspe_pkg::core_idle && job_start) begin
            rd_addr  <= job_addr;
            rd_count <= job_count;
            op       <= job_op;
            operand  <= job_operand;
        end
        if (rd_data_valid) begin
            xf_line <= xf_next;
        end
        if (xf_valid) begin
            line_buf[wr_cnt[mspe_pkg::buf_idx_w-1:0]] <= xf_line;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mspe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mspe (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                all_core_reset,
    input  wire                                m0_waitrequest,
    input  wire  [mspe_pkg::line_w-1:0]        m0_readdata,
    input  wire                                m0_readdatavalid,
    output wire                                m0_read,
    output wire  [mspe_pkg::addr_w-1:0]        m0_address,
    output wire  [mspe_pkg::burst_w-1:0]       m0_burstcount,
    output wire                                recv_fifo_rdreq,
    input  wire  [mspe_pkg::line_w-1:0]        recv_fifo_q,
    input  wire                                recv_fifo_valid,
    output wire  [mspe_pkg::line_w-1:0]        src_data,
    output wire                                src_valid,
    output wire                                src_sop,
    output wire                                src_eop,
    input  wire                                src_ready,
    output wire  [mspe_pkg::num_cores-1:0]     core_status
);

    wire [mspe_pkg::num_cores-1:0]  job_valid;
    wire [mspe_pkg::addr_w-1:0]     job_addr;
    wire mspe_pkg::lane_op_e        job_op;
    wire [mspe_pkg::lane_w-1:0]     job_operand;
    wire [mspe_pkg::burst_w-1:0]    job_count;

    wire [mspe_pkg::num_cores-1:0]  rd_req;
    wire [mspe_pkg::addr_w-1:0]     rd_addr [mspe_pkg::num_cores];
    wire [mspe_pkg::burst_w-1:0]    rd_count [mspe_pkg::num_cores];
    wire [mspe_pkg::num_cores-1:0]  rd_grant;
    wire [mspe_pkg::num_cores-1:0]  rd_data_valid;
    wire [mspe_pkg::line_w-1:0]     rd_data;

    wire [mspe_pkg::num_cores-1:0]  core_out_valid;
    wire [mspe_pkg::line_w-1:0]     core_out_data [mspe_pkg::num_cores];
    wire [mspe_pkg::num_cores-1:0]  core_out_sop;
    wire [mspe_pkg::num_cores-1:0]  core_out_eop;
    wire [mspe_pkg::num_cores-1:0]  core_out_ready;

    job_decoder i_job_decoder (
        .clk(clk),
        .rst(rst),
        .soft_rst(all_core_reset),
        .recv_fifo_valid(recv_fifo_valid),
        .recv_fifo_q(recv_fifo_q),
        .recv_fifo_rdreq(recv_fifo_rdreq),
        .core_busy(core_status),
        .job_valid(job_valid),
        .job_addr(job_addr),
        .job_op(job_op),
        .job_operand(job_operand),
        .job_count(job_count)
    );

    // the arbiter keeps counting beats of a burst that a soft reset orphaned
    dram_read_arbiter i_dram_read_arbiter (
        .clk(clk),
        .rst(rst),
        .rd_req(rd_req),
        .rd_addr(rd_addr),
        .rd_count(rd_count),
        .rd_grant(rd_grant),
        .rd_data_valid(rd_data_valid),
        .rd_data(rd_data),
        .m0_waitrequest(m0_waitrequest),
        .m0_readdata(m0_readdata),
        .m0_readdatavalid(m0_readdatavalid),
        .m0_read(m0_read),
        .m0_address(m0_address),
        .m0_burstcount(m0_burstcount)
    );

    for (genvar i = 0; i < mspe_pkg::num_cores; i++) begin : gen_core
        lane_core i_lane_core (
            .clk(clk),
            .rst(rst),
            .soft_rst(all_core_reset),
            .job_start(job_valid[i]),
            .job_addr(job_addr),
            .job_op(job_op),
            .job_operand(job_operand),
            .job_count(job_count),
            .busy(core_status[i]),
            .rd_req(rd_req[i]),
            .rd_addr(rd_addr[i]),
            .rd_count(rd_count[i]),
            .rd_grant(rd_grant[i]),
            .rd_data_valid(rd_data_valid[i]),
            .rd_data(rd_data),
            .core_out_valid(core_out_valid[i]),
            .core_out_data(core_out_data[i]),
            .core_out_sop(core_out_sop[i]),
            .core_out_eop(core_out_eop[i]),
            .core_out_ready(core_out_ready[i])
        );
    end

    packet_merger i_packet_merger (
        .clk(clk),
        .rst(rst || all_core_reset), // a flushed core would leave the lock hanging
        .core_out_valid(core_out_valid),
        .core_out_data(core_out_data),
        .core_out_sop(core_out_sop),
        .core_out_eop(core_out_eop),
        .core_out_ready(core_out_ready),
        .src_ready(src_ready),
        .src_valid(src_valid),
        .src_data(src_data),
        .src_sop(src_sop),
        .src_eop(src_eop)
    );

endmodule

`default_nettype wire

// ==== rtl/mspe_pkg.sv ====
`default_nettype none

package mspe_pkg;

    localparam int num_cores  = 2;
    localparam int core_idx_w = $clog2(num_cores);
    localparam int line_w     = 512;
    localparam int lane_w     = 32;
    localparam int num_lanes  = line_w / lane_w;
    localparam int addr_w     = 64;
    localparam int burst_w    = 3;
    localparam int max_lines  = 4;
    localparam int buf_idx_w  = $clog2(max_lines);

    // each descriptor field is a 32-bit word at a fixed offset
    localparam int field_w     = 32;
    localparam int addr_lsb    = 0;
    localparam int opcode_lsb  = 32;
    localparam int operand_lsb = 64;
    localparam int count_lsb   = 448;

    typedef enum logic [lane_w-1:0] {
        op_pass = 32'd0,
        op_add  = 32'd1,
        op_xor  = 32'd2,
        op_swap = 32'd3
    } lane_op_e;

    typedef enum logic [1:0] {
        core_idle,
        core_request,
        core_receive,
        core_drain
    } core_state_e;

endpackage

`default_nettype wire

// ==== rtl/packet_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_merger (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [mspe_pkg::num_cores-1:0]     core_out_valid,
    input  wire  [mspe_pkg::line_w-1:0]        core_out_data [mspe_pkg::num_cores],
    input  wire  [mspe_pkg::num_cores-1:0]     core_out_sop,
    input  wire  [mspe_pkg::num_cores-1:0]     core_out_eop,
    output logic [mspe_pkg::num_cores-1:0]     core_out_ready,
    input  wire                                src_ready,
    output logic                               src_valid,
    output logic [mspe_pkg::line_w-1:0]        src_data,
    output logic                               src_sop,
    output logic                               src_eop
);

    logic                              locked;
    logic [mspe_pkg::core_idx_w-1:0]   owner;
    logic [mspe_pkg::core_idx_w-1:0]   rr_ptr;
    logic [mspe_pkg::core_idx_w-1:0]   pick;
    logic                              pick_ok;

    always_comb begin
        int idx;
        pick    = rr_ptr;
        pick_ok = 1'b0;
        for (int k = mspe_pkg::num_cores - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % mspe_pkg::num_cores;
            if (core_out_valid[idx] && core_out_sop[idx]) begin
                pick    = idx[mspe_pkg::core_idx_w-1:0];
                pick_ok = 1'b1;
            end
        end
    end

    // only the locked core reaches the port, so nothing moves under back-pressure
    assign src_valid = locked && core_out_valid[owner];
    assign src_data  = core_out_data[owner];
    assign src_sop   = core_out_sop[owner];
    assign src_eop   = core_out_eop[owner];

    always_comb begin
        core_out_ready        = '0;
        core_out_ready[owner] = locked && src_ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= '0;
            rr_ptr <= '0;
        end else if (!locked) begin
            if (pick_ok) begin
                locked <= 1'b1;
                owner  <= pick;
            end
        end else if (src_valid && src_ready && src_eop) begin
            locked <= 1'b0;
            rr_ptr <= owner + 1'b1; // next packet search starts past this core
        end
    end

endmodule

`default_nettype wire

// ==== sim/mspe_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mspe_asserts (
    input wire                                clk,
    input wire                                rst,
    input wire                                all_core_reset,
    input wire                                src_valid,
    input wire                                src_ready,
    input wire  [mspe_pkg::line_w-1:0]        src_data,
    input wire                                src_sop,
    input wire                                src_eop,
    input wire                                m0_read,
    input wire                                m0_waitrequest,
    input wire  [mspe_pkg::addr_w-1:0]        m0_address,
    input wire  [mspe_pkg::burst_w-1:0]       m0_burstcount,
    input wire                                m0_readdatavalid
);

    logic       in_pkt; // a packet has started on the source port and not ended
    logic [3:0] beats_due; // lines still owed by DRAM for the accepted burst
    logic       accept;

    assign accept = m0_read && !m0_waitrequest;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_due <= '0;
        end else begin
            beats_due <= beats_due + (accept ? {1'b0, m0_burstcount} : 4'd0)
                         - (m0_readdatavalid ? 4'd1 : 4'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || all_core_reset) begin
            in_pkt <= 1'b0;
        end else if (src_valid && src_ready) begin
            in_pkt <= !src_eop;
        end
    end

    src_holds: assert property (@(posedge clk) disable iff (rst || all_core_reset)
        src_valid && !src_ready |=>
            src_valid && $stable(src_data) && $stable(src_sop) && $stable(src_eop))
        else $error("source outputs changed while src_ready was low");

    no_sop_inside: assert property (@(posedge clk) disable iff (rst || all_core_reset)
        src_valid && in_pkt |-> !src_sop)
        else $error("src_sop seen inside an open packet");

    sop_opens: assert property (@(posedge clk) disable iff (rst || all_core_reset)
        src_valid && !in_pkt |-> src_sop)
        else $error("a packet began without src_sop");

    m0_holds: assert property (@(posedge clk) disable iff (rst)
        m0_read && m0_waitrequest |=>
            m0_read && $stable(m0_address) && $stable(m0_burstcount))
        else $error("DRAM read command changed while waitrequest was high");

    one_burst: assert property (@(posedge clk) disable iff (rst)
        $rose(m0_read) |-> beats_due == 4'd0)
        else $error("a new DRAM read started before the previous burst returned");

    data_owed: assert property (@(posedge clk) disable iff (rst)
        m0_readdatavalid |-> beats_due != 4'd0)
        else $error("DRAM returned a line that no burst asked for");

endmodule

bind mspe mspe_asserts i_mspe_asserts (
    .clk(clk),
    .rst(rst),
    .all_core_reset(all_core_reset),
    .src_valid(src_valid),
    .src_ready(src_ready),
    .src_data(src_data),
    .src_sop(src_sop),
    .src_eop(src_eop),
    .m0_read(m0_read),
    .m0_waitrequest(m0_waitrequest),
    .m0_address(m0_address),
    .m0_burstcount(m0_burstcount),
    .m0_readdatavalid(m0_readdatavalid)
);

`default_nettype wire

// ==== sim/mspe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mspe_tb;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] op;
        logic [31:0] operand;
        logic [2:0]  count;
    } job_t;

    localparam int total_jobs      = 15;
    localparam int watchdog_cycles = total_jobs * 200;

    logic                               clk              = 1'b0;
    logic                               rst              = 1'b1;
    logic                               all_core_reset   = 1'b0;
    logic                               m0_waitrequest   = 1'b1;
    logic [mspe_pkg::line_w-1:0]        m0_readdata      = '0;
    logic                               m0_readdatavalid = 1'b0;
    logic                               recv_fifo_valid  = 1'b0;
    logic [mspe_pkg::line_w-1:0]        recv_fifo_q      = '0;
    logic                               src_ready        = 1'b0;
    wire                                m0_read;
    wire  [mspe_pkg::addr_w-1:0]        m0_address;
    wire  [mspe_pkg::burst_w-1:0]       m0_burstcount;
    wire                                recv_fifo_rdreq;
    wire  [mspe_pkg::line_w-1:0]        src_data;
    wire                                src_valid;
    wire                                src_sop;
    wire                                src_eop;
    wire  [mspe_pkg::num_cores-1:0]     core_status;

    logic [31:0]                        lfsr_state = 32'h48a2_c280;
    logic [mspe_pkg::line_w-1:0]        desc_queue [$]; // receive FIFO contents, head first
    job_t                               pending [$]; // jobs whose packet has not started
    job_t                               cur_job;
    int                                 beat;
    logic                               in_pkt     = 1'b0;
    int                                 job_seq    = 0;
    logic [31:0]                        burst_addr;
    int                                 beats_left = 0;
    int                                 beat_idx;

    always #4 clk = ~clk;

    mspe i_mspe (
        .clk(clk),
        .rst(rst),
        .all_core_reset(all_core_reset),
        .m0_waitrequest(m0_waitrequest),
        .m0_readdata(m0_readdata),
        .m0_readdatavalid(m0_readdatavalid),
        .m0_read(m0_read),
        .m0_address(m0_address),
        .m0_burstcount(m0_burstcount),
        .recv_fifo_rdreq(recv_fifo_rdreq),
        .recv_fifo_q(recv_fifo_q),
        .recv_fifo_valid(recv_fifo_valid),
        .src_data(src_data),
        .src_valid(src_valid),
        .src_sop(src_sop),
        .src_eop(src_eop),
        .src_ready(src_ready),
        .core_status(core_status)
    );

    // taps of x^32 + x^22 + x^2 + x + 1 with one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] apply_op(input logic [31:0] op, input logic [31:0] k,
                                             input logic [31:0] w);
        logic [31:0] r;
        r = w; // pass, and unknown opcodes too
        if (op == 32'd1) begin
            r = w + k;
        end else if (op == 32'd2) begin
            r = w ^ k;
        end else if (op == 32'd3) begin
            for (int b = 0; b < 4; b++) begin
                r[b*8 +: 8] = w[(3-b)*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [mspe_pkg::line_w-1:0] model_line(input logic [31:0] a);
        logic [mspe_pkg::line_w-1:0] l;
        for (int i = 0; i < mspe_pkg::num_lanes; i++) begin
            l[i*32 +: 32] = a ^ (32'(i) * 32'h0101_0101);
        end
        return l;
    endfunction

    function automatic logic [mspe_pkg::line_w-1:0] expect_line(input job_t j, input int n);
        logic [mspe_pkg::line_w-1:0] raw;
        logic [mspe_pkg::line_w-1:0] res;
        raw = model_line(j.addr + 32'(n) * 32'd64);
        for (int i = 0; i < mspe_pkg::num_lanes; i++) begin
            res[i*32 +: 32] = apply_op(j.op, j.operand, raw[i*32 +: 32]);
        end
        return res;
    endfunction

    function automatic logic [mspe_pkg::line_w-1:0] make_desc(input job_t j);
        logic [mspe_pkg::line_w-1:0] d;
        d = '0;
        d[mspe_pkg::addr_lsb +: 32]    = j.addr;
        d[mspe_pkg::opcode_lsb +: 32]  = j.op;
        d[mspe_pkg::operand_lsb +: 32] = j.operand;
        d[mspe_pkg::count_lsb +: 32]   = {29'd0, j.count};
        return d;
    endfunction

    task automatic fail_with(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // operand top nibbles keep the first lane of every job distinct
    task automatic push_job(input logic [31:0] op, input int count);
        job_t        j;
        logic [31:0] rnd;
        @(negedge clk);
        rnd       = take_bits(12);
        j.addr    = 32'h1000_0000 + 32'(job_seq) * 32'h100;
        j.op      = op;
        j.count   = 3'(count);
        if (op == 32'd1) begin
            j.operand = {4'h4, rnd[11:0], 16'h0};
        end else if (op == 32'd2) begin
            j.operand = {4'h8, rnd[11:0], 16'h0};
        end else begin
            j.operand = take_bits(32);
        end
        desc_queue.push_back(make_desc(j));
        pending.push_back(j);
        job_seq++;
    endtask

    task automatic wait_idle();
        while (desc_queue.size() != 0 || pending.size() != 0 || in_pkt) begin
            @(negedge clk);
        end
        @(negedge clk);
        assert (core_status == '0)
            else fail_with($sformatf("mismatch core_status expected 0 got %h", core_status));
    endtask

    // receive FIFO, DRAM and sink models
    always @(posedge clk) begin
        if (recv_fifo_rdreq) begin
            desc_queue.delete(0);
        end
        recv_fifo_valid <= (desc_queue.size() != 0);
        recv_fifo_q     <= (desc_queue.size() != 0) ? desc_queue[0] : '0;
        if (m0_read && !m0_waitrequest) begin
            burst_addr = m0_address[31:0];
            beats_left = int'(m0_burstcount);
            beat_idx   = 0;
            foreach (pending[j]) begin
                if (pending[j].addr == burst_addr) begin
                    assert (m0_burstcount == pending[j].count)
                        else fail_with($sformatf("mismatch m0_burstcount expected %h got %h",
                                                 pending[j].count, m0_burstcount));
                end
            end
        end
        if (beats_left > 0 && take_bits(2) != 32'd0) begin
            m0_readdatavalid <= 1'b1;
            m0_readdata      <= model_line(burst_addr + 32'(beat_idx) * 32'd64);
            beat_idx++;
            beats_left--;
        end else begin
            m0_readdatavalid <= 1'b0;
        end
        m0_waitrequest <= (take_bits(2) == 32'd0);
        src_ready      <= (take_bits(2) != 32'd0);
    end

    // a sop is matched back to its job through lane 0 of the first beat
    always @(posedge clk) begin
        int                          found;
        logic [mspe_pkg::line_w-1:0] want;
        if (!rst) begin
            assert (!(recv_fifo_rdreq && (!recv_fifo_valid || (&core_status))))
                else fail_with("recv_fifo_rdreq was high with no descriptor or no idle core");
            if (all_core_reset) begin
                pending.delete();
                in_pkt = 1'b0;
            end else if (src_valid && src_ready) begin
                if (!in_pkt) begin
                    assert (src_sop)
                        else fail_with("mismatch src_sop expected 1 got 0");
                    found = -1;
                    foreach (pending[j]) begin
                        if (apply_op(pending[j].op, pending[j].operand, pending[j].addr)
                                == src_data[31:0]) begin
                            found = j;
                        end
                    end
                    assert (found >= 0)
                        else fail_with("a packet arrived that matches no pending job");
                    cur_job = pending[found];
                    pending.delete(found);
                    beat    = 0;
                    in_pkt  = 1'b1;
                end else begin
                    assert (!src_sop)
                        else fail_with("mismatch src_sop expected 0 got 1");
                end
                want = expect_line(cur_job, beat);
                assert (src_data == want)
                    else fail_with($sformatf("mismatch src_data expected %h got %h",
                                             want, src_data));
                assert (src_eop == (beat + 1 == int'(cur_job.count)))
                    else fail_with($sformatf("mismatch src_eop expected %h got %h",
                                             (beat + 1 == int'(cur_job.count)), src_eop));
                if (src_eop) begin
                    in_pkt = 1'b0;
                end else begin
                    beat++;
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_with("timeout: the jobs did not finish in time");
    end

    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // more jobs than cores, every opcode and every line count
        for (int i = 0; i < 12; i++) begin
            push_job((i % 5 == 4) ? 32'd7 : 32'(i % 5), (i % 4) + 1);
        end
        wait_idle();
        push_job(32'd2, 4);
        push_job(32'd1, 4);
        while (desc_queue.size() != 0 || !src_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
        all_core_reset <= 1'b1;
        @(posedge clk);
        all_core_reset <= 1'b0;
        @(negedge clk);
        assert (core_status == '0)
            else fail_with($sformatf("mismatch core_status expected 0 got %h", core_status));
        repeat (40) begin
            @(negedge clk);
            assert (!(src_valid && src_sop))
                else fail_with("a packet started after the soft reset with no new job");
        end
        push_job(32'd3, 3);
        wait_idle();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
